// File: project.f
src/msi_pkg.sv
src/msi_irq_capture.sv
src/msi_vec_fifo.sv
src/msi_issue.sv
src/msi_irq_top.sv
tb/msi_irq_props.sv
tb/msi_irq_tb.sv

// File: tb/msi_irq_tb.sv
// Testbench for the MSI interrupt path with a PCIe hard block model and directed tests
`timescale 1ns/1ps
`default_nettype none

module msi_irq_tb import msi_pkg::*; ();

    // All tests together take a few hundred cycles
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int QUIET_CYCLES = 30;
    localparam int REQ_WAIT_LIMIT = 200;

    logic     pcie_clk;
    logic     pcie_rst;
    irq_t     irq;
    logic     cfg_interrupt_msi_enable;
    msi_int_t cfg_interrupt_msi_int;
    logic     cfg_interrupt_msi_sent;
    logic     cfg_interrupt_msi_fail;

    // Bit index of every request seen by the hard block model
    int req_q[$];

    // Number of fail answers the model gives before answering sent
    int fail_budget;

    int cycle_count;
    logic [31:0] rand_state;

    msi_irq_top uut (
        .pcie_clk                 (pcie_clk),
        .pcie_rst                 (pcie_rst),
        .irq                      (irq),
        .cfg_interrupt_msi_enable (cfg_interrupt_msi_enable),
        .cfg_interrupt_msi_int    (cfg_interrupt_msi_int),
        .cfg_interrupt_msi_sent   (cfg_interrupt_msi_sent),
        .cfg_interrupt_msi_fail   (cfg_interrupt_msi_fail)
    );

    initial begin
        pcie_clk = 1'b0;
        forever begin
            #20 pcie_clk = ~pcie_clk;
        end
    end

    always @(posedge pcie_clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        abort_run($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // Lands 2 ns after the n-th rising edge
    task automatic step(input int n);
        repeat (n) @(posedge pcie_clk);
        #2;
    endtask

    task automatic pulse_irq(input irq_t mask);
        irq = mask;
        step(1);
        irq = '0;
    endtask

    // Hard block model logs each request and answers fail or sent after 1 to 4 cycles
    task automatic hard_block_model();
        int idx;
        int delay;
        forever begin
            @(negedge pcie_clk);
            if (!pcie_rst && cfg_interrupt_msi_int != '0) begin
                idx = 0;
                for (int i = 0; i < MSI_CNT; i++) begin
                    if (cfg_interrupt_msi_int[i]) begin
                        idx = i;
                    end
                end
                check_value("cfg_interrupt_msi_int", cfg_interrupt_msi_int, 32'h1 << idx);
                req_q.push_back(idx);
                delay = 1 + int'((next_rand() >> 16) % 4);
                step(delay);
                if (fail_budget > 0) begin
                    fail_budget--;
                    cfg_interrupt_msi_fail = 1'b1;
                end else begin
                    cfg_interrupt_msi_sent = 1'b1;
                end
                step(1);
                cfg_interrupt_msi_sent = 1'b0;
                cfg_interrupt_msi_fail = 1'b0;
            end
        end
    endtask

    initial begin
        hard_block_model();
    end

    task automatic wait_for_requests(input int n);
        int waited;
        waited = 0;
        while (req_q.size() < n && waited < REQ_WAIT_LIMIT) begin
            step(1);
            waited++;
        end
        if (req_q.size() < n) begin
            abort_run($sformatf("Expected %0d MSI requests but only %0d arrived in %0d cycles",
                                n, req_q.size(), REQ_WAIT_LIMIT));
        end
    endtask

    // Quiet window afterwards catches any extra request
    task automatic expect_requests(input int exp[$]);
        wait_for_requests(exp.size());
        step(QUIET_CYCLES);
        check_value("request count", req_q.size(), exp.size());
        foreach (exp[i]) begin
            check_value("cfg_interrupt_msi_int index", req_q[i], exp[i]);
        end
        req_q.delete();
    endtask

    task automatic test_single_request();
        cfg_interrupt_msi_enable = 1'b1;
        pulse_irq(8'h08);
        expect_requests('{3});
    endtask

    task automatic test_retry_on_fail();
        fail_budget = 1;
        pulse_irq(8'h20);
        expect_requests('{5, 5});
    endtask

    task automatic test_enable_gating();
        cfg_interrupt_msi_enable = 1'b0;
        pulse_irq(8'h02);
        step(50);
        check_value("request count", req_q.size(), 0);
        cfg_interrupt_msi_enable = 1'b1;
        expect_requests('{1});
    endtask

    // Capture hands on the lowest pending index first
    task automatic test_priority_order();
        pulse_irq(8'h45);
        expect_requests('{0, 2, 6});
    endtask

    // FIFO takes 0 to 3, 4 and 5 stay pending and the repeat of 4 merges
    task automatic test_backpressure_merge();
        cfg_interrupt_msi_enable = 1'b0;
        pulse_irq(8'h3f);
        step(10);
        pulse_irq(8'h10);
        step(10);
        check_value("request count", req_q.size(), 0);
        cfg_interrupt_msi_enable = 1'b1;
        expect_requests('{0, 1, 2, 3, 4, 5});
    endtask

    initial begin
        pcie_rst = 1'b1;
        irq = '0;
        cfg_interrupt_msi_enable = 1'b0;
        cfg_interrupt_msi_sent = 1'b0;
        cfg_interrupt_msi_fail = 1'b0;
        fail_budget = 0;
        rand_state = 32'h049d_7ead;
        step(5);
        pcie_rst = 1'b0;
        step(2);

        test_single_request();
        test_retry_on_fail();
        test_enable_gating();
        test_priority_order();
        test_backpressure_merge();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/msi_irq_props.sv
// MSI output properties bound to the interrupt path top level
`timescale 1ns/1ps
`default_nettype none

module msi_irq_props import msi_pkg::*; (
    input logic     pcie_clk,
    input logic     pcie_rst,
    input msi_int_t cfg_interrupt_msi_int
);

    // At most one vector requested at a time
    a_zero_or_onehot: assert property (
        @(posedge pcie_clk) disable iff (pcie_rst)
        $onehot0(cfg_interrupt_msi_int)
    ) else $error("cfg_interrupt_msi_int has more than one bit set");

    // Request is a single-cycle pulse
    a_single_cycle: assert property (
        @(posedge pcie_clk) disable iff (pcie_rst)
        (cfg_interrupt_msi_int != '0) |=> (cfg_interrupt_msi_int == '0)
    ) else $error("cfg_interrupt_msi_int held for more than one cycle");

    // Quiet while reset is applied
    a_zero_in_reset: assert property (
        @(posedge pcie_clk)
        pcie_rst |=> (cfg_interrupt_msi_int == '0)
    ) else $error("cfg_interrupt_msi_int nonzero during reset");

endmodule

bind msi_irq_top msi_irq_props props_inst (
    .pcie_clk              (pcie_clk),
    .pcie_rst              (pcie_rst),
    .cfg_interrupt_msi_int (cfg_interrupt_msi_int)
);

`default_nettype wire

// File: src/msi_irq_top.sv
// MSI interrupt path top level chaining capture stage, vector FIFO and MSI issuer
`timescale 1ns/1ps
`default_nettype none

module msi_irq_top import msi_pkg::*; (
    input  logic     pcie_clk,
    input  logic     pcie_rst,

    // Interrupt sources
    input  irq_t     irq,

    // PCIe hard block MSI interface
    input  logic     cfg_interrupt_msi_enable,
    output msi_int_t cfg_interrupt_msi_int,
    input  logic     cfg_interrupt_msi_sent,
    input  logic     cfg_interrupt_msi_fail
);

    // Capture to FIFO
    logic     cap_valid;
    msi_vec_t cap_vec;
    logic     cap_ready;

    // FIFO to issuer
    logic     fifo_valid;
    msi_vec_t fifo_vec;
    logic     fifo_ready;

    msi_irq_capture capture_inst (
        .pcie_clk  (pcie_clk),
        .pcie_rst  (pcie_rst),
        .irq       (irq),
        .cap_valid (cap_valid),
        .cap_vec   (cap_vec),
        .cap_ready (cap_ready)
    );

    msi_vec_fifo fifo_inst (
        .pcie_clk  (pcie_clk),
        .pcie_rst  (pcie_rst),
        .in_valid  (cap_valid),
        .in_vec    (cap_vec),
        .in_ready  (cap_ready),
        .out_valid (fifo_valid),
        .out_vec   (fifo_vec),
        .out_ready (fifo_ready)
    );

    msi_issue issue_inst (
        .pcie_clk                 (pcie_clk),
        .pcie_rst                 (pcie_rst),
        .vec_valid                (fifo_valid),
        .vec                      (fifo_vec),
        .vec_ready                (fifo_ready),
        .cfg_interrupt_msi_enable (cfg_interrupt_msi_enable),
        .cfg_interrupt_msi_int    (cfg_interrupt_msi_int),
        .cfg_interrupt_msi_sent   (cfg_interrupt_msi_sent),
        .cfg_interrupt_msi_fail   (cfg_interrupt_msi_fail)
    );

endmodule

`default_nettype wire

// File: src/msi_issue.sv
// MSI issuer that pulses one-hot requests to the PCIe hard block and retries on fail
`timescale 1ns/1ps
`default_nettype none

module msi_issue import msi_pkg::*; (
    input  logic     pcie_clk,
    input  logic     pcie_rst,

    // Vector input from the FIFO
    input  logic     vec_valid,
    input  msi_vec_t vec,
    output logic     vec_ready,

    // PCIe hard block MSI interface
    input  logic     cfg_interrupt_msi_enable,
    output msi_int_t cfg_interrupt_msi_int,
    input  logic     cfg_interrupt_msi_sent,
    input  logic     cfg_interrupt_msi_fail
);

    issue_state_t state;

    // Vector currently being delivered, kept for a retry
    msi_vec_t vec_q;

    // Request pulse register
    msi_int_t msi_int_q;

    logic vec_xfer;

    // Enable gates only new vectors and never a retry
    assign vec_ready = (state == IDLE) && cfg_interrupt_msi_enable;
    assign vec_xfer = vec_valid && vec_ready;

    assign cfg_interrupt_msi_int = msi_int_q;

    // Payload latch
    always_ff @(posedge pcie_clk) begin
        if (vec_xfer) begin
            vec_q <= vec;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            state <= IDLE;
            msi_int_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    msi_int_q <= '0;
                    if (vec_xfer) begin
                        msi_int_q <= msi_int_t'(1) << vec;
                        state <= REQ;
                    end
                end

                // Pulse is high for this one cycle only
                REQ: begin
                    msi_int_q <= '0;
                    state <= WAIT_ACK;
                end

                WAIT_ACK: begin
                    msi_int_q <= '0;
                    if (cfg_interrupt_msi_sent) begin
                        state <= IDLE;
                    end else if (cfg_interrupt_msi_fail) begin
                        // Reissue the same vector next cycle
                        msi_int_q <= msi_int_t'(1) << vec_q;
                        state <= REQ;
                    end
                end

                default: begin
                    msi_int_q <= '0;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/msi_vec_fifo.sv
// Four-entry register FIFO for MSI vector numbers with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module msi_vec_fifo import msi_pkg::*; (
    input  logic     pcie_clk,
    input  logic     pcie_rst,

    // Write side
    input  logic     in_valid,
    input  msi_vec_t in_vec,
    output logic     in_ready,

    // Read side
    output logic     out_valid,
    output msi_vec_t out_vec,
    input  logic     out_ready
);

    msi_vec_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;

    // One extra bit so a full FIFO is distinct from an empty one
    logic [FIFO_PTR_W:0] count;

    logic wr_en;
    logic rd_en;

    assign in_ready = count != (FIFO_PTR_W + 1)'(FIFO_DEPTH);
    assign out_valid = count != '0;
    assign out_vec = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage
    always_ff @(posedge pcie_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_vec;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count unchanged
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/msi_irq_capture.sv
// Interrupt capture stage turning rising edges on irq lines into pending MSI vector numbers
`timescale 1ns/1ps
`default_nettype none

module msi_irq_capture import msi_pkg::*; (
    input  logic     pcie_clk,
    input  logic     pcie_rst,

    // Interrupt source lines
    input  irq_t     irq,

    // Vector output toward the FIFO
    output logic     cap_valid,
    output msi_vec_t cap_vec,
    input  logic     cap_ready
);

    // Previous sample of the irq lines
    irq_t irq_q;

    // One bit per source waiting to be handed on
    irq_t pending;

    irq_t irq_rise;
    irq_t pending_clr;
    logic cap_xfer;

    // Rising edge means high now and low at the previous edge
    assign irq_rise = irq & ~irq_q;

    assign cap_valid = |pending;
    assign cap_xfer = cap_valid && cap_ready;

    // Lowest-index pending source wins
    always_comb begin
        cap_vec = '0;
        for (int i = IRQ_CNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                cap_vec = msi_vec_t'(i);
            end
        end
    end

    // Bit of the vector leaving this cycle
    always_comb begin
        pending_clr = '0;
        if (cap_xfer) begin
            pending_clr = irq_t'(1) << cap_vec;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            irq_q <= '0;
            pending <= '0;
        end else begin
            irq_q <= irq;
            // New edges OR in after the clear, so a fresh edge on the
            // outgoing bit sets it again
            pending <= (pending & ~pending_clr) | irq_rise;
        end
    end

endmodule

`default_nettype wire

// File: src/msi_pkg.sv
// MSI interrupt path package with source counts, vector widths and issuer states
`default_nettype none

package msi_pkg;

    // Interrupt source lines feeding the capture stage
    localparam int IRQ_CNT = 8;

    // Vectors accepted by the PCIe hard block, width of cfg_interrupt_msi_int
    localparam int MSI_CNT = 32;
    localparam int VEC_W = 5;

    // Vector FIFO sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

    typedef logic [IRQ_CNT-1:0] irq_t;
    typedef logic [VEC_W-1:0]   msi_vec_t;
    typedef logic [MSI_CNT-1:0] msi_int_t;

    // Issuer FSM
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REQ      = 2'd1,
        WAIT_ACK = 2'd2
    } issue_state_t;

endpackage

`default_nettype wire
